// File: dv/cam_bringup_tests.txt
# name kind cycles drive led outs frame_rate jpeg_rate, all but cycles in hex
# kinds rst run wait pulse rate; pulse gives vsync count in cycles, jpeg count in drive
# drive bit 0 mac_init_done 1 cam_init_done 2 pclk_run 3 mac_mdc 4 mac_mdio_o
# 5 mac_mdio_oe 6 cam_scl_o 7 cam_scl_oe 8 cam_sda_o 9 cam_sda_oe
# outs bit 0 mac_rst_n 1 cam_rst_n 2 stream_en 3 scl_mdc 4 scl_mdc_oe 5 sda_mdio 6 sda_mdio_oe
# rate waits for the cycle count since reset release, modulo the rate window
reset_state   rst   10  128 3f 58 00 00
mac_release   run   2   128 3e 59 00 00
mac_wait      run   5   128 3e 59 00 00
mac_done      run   1   129 3c 23 00 00
cam_init_hold run   3   129 3c 23 00 00
pclk_pass     wait  66  12f 38 27 00 00
stream_hold   run   70  12f 38 27 00 00
rate_align    rate  16  0   38 27 00 00
events        pulse 5   2   18 27 00 00
rate_check    rate  4   0   18 27 05 02
rate_next     rate  4   0   18 27 00 00
pclk_stop     wait  140 128 10 59 00 00
mac_reinit    run   3   129 10 23 00 00

// File: vlog.f
+incdir+rtl
rtl/cam_bringup_pkg.sv
rtl/pclk_monitor.sv
rtl/bringup_ctrl.sv
rtl/rate_meter.sv
rtl/cam_bringup_top.sv
dv/cam_bringup_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cam_bringup_tb \
    -o cam_bringup_sim > "$LOG" 2>&1 \
    && ./obj_dir/cam_bringup_sim >> "$LOG" 2>&1 \
    || echo "build or run error, Simulation failed" >> "$LOG"

cat "$LOG"
grep -q "Simulation failed" "$LOG" && exit 1
grep -q "Simulation completed successfully" "$LOG" || exit 1
exit 0

// File: dv/cam_bringup_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_bringup_cfg.svh"

module cam_bringup_tb;

    localparam string TEST_FILE = "dv/cam_bringup_tests.txt";
    localparam int    MAX_STEPS = 32;
    localparam int    K_RST     = 0;
    localparam int    K_RUN     = 1;
    localparam int    K_WAIT    = 2;
    localparam int    K_PULSE   = 3;
    localparam int    K_RATE    = 4;

    logic cam_port;
    logic rst_n;
    logic i_cmos_pclk;
    logic i_mac_init_done;
    logic i_cam_init_done;
    logic i_mac_mdc;
    logic i_mac_mdio_o;
    logic i_mac_mdio_oe;
    logic i_cam_scl_o;
    logic i_cam_scl_oe;
    logic i_cam_sda_o;
    logic i_cam_sda_oe;
    logic i_vsync;
    logic i_jpeg_done;
    logic o_mac_rst_n;
    logic o_cam_rst_n;
    logic o_stream_en;
    logic [`STAGE_LED_W-1:0] o_stage_led;
    logic o_scl_mdc;
    logic o_scl_mdc_oe;
    logic o_sda_mdio;
    logic o_sda_mdio_oe;
    cam_bringup_pkg::rate_count_t o_frame_rate;
    cam_bringup_pkg::rate_count_t o_jpeg_rate;
    logic o_frame_led;
    logic o_jpeg_led;
    logic [5:0] o_led;

    // pclk generator state
    logic        pclk_run = 1'b0;
    integer      seed = 16;
    int unsigned jitter;

    // steps read from the data file
    string                        t_name [MAX_STEPS];
    int                           t_kind [MAX_STEPS];
    int                           t_cyc  [MAX_STEPS];
    logic [15:0]                  t_drv  [MAX_STEPS];
    logic [5:0]                   t_led  [MAX_STEPS];
    logic [6:0]                   t_outs [MAX_STEPS];
    cam_bringup_pkg::rate_count_t t_frame[MAX_STEPS];
    cam_bringup_pkg::rate_count_t t_jpeg [MAX_STEPS];
    int n_steps = 0;
    int limit   = 0;
    int cyc;
    int checks  = 0;
    int errors  = 0;

    cam_bringup_top cam_bringup_top_i (.*);

    always #50 cam_port = ~cam_port;

    // cycles since reset release
    // lines up with the rate window
    always @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // free running pclk with half period 120 to 150 ns
    // about 21 or more edges per check window
    always begin
        if (pclk_run) begin
            jitter = $unsigned($random(seed)) % 31;
            #(120 + jitter);
            i_cmos_pclk <= ~i_cmos_pclk;
        end else begin
            @(posedge pclk_run);
        end
    end

    function automatic logic [6:0] out_bits();
        return {o_sda_mdio_oe, o_sda_mdio, o_scl_mdc_oe, o_scl_mdc,
                o_stream_en, o_cam_rst_n, o_mac_rst_n};
    endfunction

    // one bit per input in the data file header layout
    task automatic apply_drive(input logic [15:0] d);
        i_mac_init_done <= d[0];
        i_cam_init_done <= d[1];
        pclk_run        <= d[2];
        i_mac_mdc       <= d[3];
        i_mac_mdio_o    <= d[4];
        i_mac_mdio_oe   <= d[5];
        i_cam_scl_o     <= d[6];
        i_cam_scl_oe    <= d[7];
        i_cam_sda_o     <= d[8];
        i_cam_sda_oe    <= d[9];
    endtask

    task automatic check_bit(input string test, input string what, input logic exp,
                             input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %0s %0s expected %0b actual %0b", test, what, exp, act);
        end
    endtask

    task automatic check_led(input string test, input logic [5:0] exp, input logic [5:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %0s o_led expected %b actual %b", test, exp, act);
        end
    endtask

    task automatic check_stage(input string test, input logic [`STAGE_LED_W-1:0] exp,
                               input logic [`STAGE_LED_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %0s o_stage_led expected %b actual %b", test, exp, act);
        end
    endtask

    task automatic check_rate(input string test, input string what,
                              input cam_bringup_pkg::rate_count_t exp,
                              input cam_bringup_pkg::rate_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %0s %0s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_step(input int i);
        check_led(t_name[i], t_led[i], o_led);
        check_stage(t_name[i], t_led[i][`STAGE_LED_W-1:0], o_stage_led);
        check_bit(t_name[i], "o_jpeg_led", t_led[i][4], o_jpeg_led);
        check_bit(t_name[i], "o_frame_led", t_led[i][5], o_frame_led);
        check_bit(t_name[i], "o_mac_rst_n", t_outs[i][0], o_mac_rst_n);
        check_bit(t_name[i], "o_cam_rst_n", t_outs[i][1], o_cam_rst_n);
        check_bit(t_name[i], "o_stream_en", t_outs[i][2], o_stream_en);
        check_bit(t_name[i], "o_scl_mdc", t_outs[i][3], o_scl_mdc);
        check_bit(t_name[i], "o_scl_mdc_oe", t_outs[i][4], o_scl_mdc_oe);
        check_bit(t_name[i], "o_sda_mdio", t_outs[i][5], o_sda_mdio);
        check_bit(t_name[i], "o_sda_mdio_oe", t_outs[i][6], o_sda_mdio_oe);
        check_rate(t_name[i], "o_frame_rate", t_frame[i], o_frame_rate);
        check_rate(t_name[i], "o_jpeg_rate", t_jpeg[i], o_jpeg_rate);
    endtask

    task automatic load_steps();
        int              fd;
        int              n;
        int              cyc_v;
        string           line;
        logic [8*24-1:0] nm;
        logic [8*24-1:0] kd;
        logic [15:0]     drv_v;
        logic [15:0]     led_v;
        logic [15:0]     outs_v;
        logic [15:0]     fr_v;
        logic [15:0]     jp_v;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test file %0s", TEST_FILE);
            errors++;
            return;
        end
        while (!$feof(fd) && n_steps < MAX_STEPS) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and comments
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%s %s %d %h %h %h %h %h", nm, kd, cyc_v, drv_v, led_v,
                        outs_v, fr_v, jp_v);
            t_kind[n_steps] = (kd == "rst")   ? K_RST   : (kd == "run")  ? K_RUN  :
                              (kd == "wait")  ? K_WAIT  : (kd == "rate") ? K_RATE :
                              (kd == "pulse") ? K_PULSE : -1;
            if (n != 8 || t_kind[n_steps] < 0) begin
                $display("skipped a malformed test line: %0s", line);
                errors++;
                continue;
            end
            t_name[n_steps]  = $sformatf("%0s", nm);
            t_cyc[n_steps]   = cyc_v;
            t_drv[n_steps]   = drv_v;
            t_led[n_steps]   = led_v[5:0];
            t_outs[n_steps]  = outs_v[6:0];
            t_frame[n_steps] = fr_v[`RATE_W-1:0];
            t_jpeg[n_steps]  = jp_v[`RATE_W-1:0];
            // worst case length of this step
            if (t_kind[n_steps] == K_RATE) begin
                limit += `RATE_WINDOW + 2;
            end else if (t_kind[n_steps] == K_PULSE) begin
                limit += 3 * (cyc_v + int'(drv_v)) + 4;
            end else begin
                limit += cyc_v + 2;
            end
            n_steps++;
        end
        $fclose(fd);
    endtask

    task automatic run_step(input int i);
        int   k;
        logic hit;
        case (t_kind[i])
            K_RST: begin
                @(posedge cam_port);
                rst_n <= 1'b0;
                apply_drive(t_drv[i]);
                repeat (t_cyc[i]) @(posedge cam_port);
                @(negedge cam_port);
                check_step(i);
                @(posedge cam_port);
                rst_n <= 1'b1;
            end
            K_RUN: begin
                @(posedge cam_port);
                apply_drive(t_drv[i]);
                repeat (t_cyc[i]) @(posedge cam_port);
                @(negedge cam_port);
                check_step(i);
            end
            K_WAIT: begin
                @(posedge cam_port);
                apply_drive(t_drv[i]);
                hit = 1'b0;
                for (k = 0; k < t_cyc[i] && !hit; k++) begin
                    @(posedge cam_port);
                    @(negedge cam_port);
                    hit = (o_led === t_led[i]) && (out_bits() === t_outs[i]);
                end
                if (!hit) begin
                    errors++;
                    $display("%0s: outputs did not settle within %0d cycles", t_name[i],
                             t_cyc[i]);
                end
                check_step(i);
            end
            K_PULSE: begin
                // one high cycle then two low per pulse
                for (k = 0; k < t_cyc[i] || k < int'(t_drv[i]); k++) begin
                    @(posedge cam_port);
                    i_vsync     <= (k < t_cyc[i]);
                    i_jpeg_done <= (k < int'(t_drv[i]));
                    @(posedge cam_port);
                    i_vsync     <= 1'b0;
                    i_jpeg_done <= 1'b0;
                    @(posedge cam_port);
                end
                repeat (2) @(posedge cam_port);
                @(negedge cam_port);
                check_step(i);
            end
            default: begin
                // K_RATE waits for a position inside the rate window
                do @(negedge cam_port); while (cyc % `RATE_WINDOW != t_cyc[i]);
                check_step(i);
            end
        endcase
    endtask

    task automatic report_counts();
        $display("steps %0d, checks %0d, errors %0d", n_steps, checks, errors);
    endtask

    initial begin
        cam_port        = 1'b0;
        rst_n           = 1'b0;
        i_cmos_pclk     = 1'b0;
        i_vsync         = 1'b0;
        i_jpeg_done     = 1'b0;
        apply_drive(16'h0000);
        load_steps();
        if (n_steps == 0) begin
            $display("no usable steps in the test file");
            errors++;
        end
        limit += 200;
        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        report_counts();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the steps in the file
    initial begin
        wait (limit > 200);
        repeat (limit) @(posedge cam_port);
        $display("timeout after %0d cycles, the steps did not finish", limit);
        report_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/cam_bringup_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_bringup_cfg.svh"

module cam_bringup_top (
    input  logic                         cam_port,
    input  logic                         rst_n,
    input  logic                         i_cmos_pclk,
    input  logic                         i_mac_init_done,
    input  logic                         i_cam_init_done,
    input  logic                         i_mac_mdc,
    input  logic                         i_mac_mdio_o,
    input  logic                         i_mac_mdio_oe,
    input  logic                         i_cam_scl_o,
    input  logic                         i_cam_scl_oe,
    input  logic                         i_cam_sda_o,
    input  logic                         i_cam_sda_oe,
    input  logic                         i_vsync,
    input  logic                         i_jpeg_done,
    output logic                         o_mac_rst_n,
    output logic                         o_cam_rst_n,
    output logic                         o_stream_en,
    output logic [`STAGE_LED_W-1:0]      o_stage_led,
    output logic                         o_scl_mdc,
    output logic                         o_scl_mdc_oe,
    output logic                         o_sda_mdio,
    output logic                         o_sda_mdio_oe,
    output cam_bringup_pkg::rate_count_t o_frame_rate,
    output cam_bringup_pkg::rate_count_t o_jpeg_rate,
    output logic                         o_frame_led,
    output logic                         o_jpeg_led,
    output logic [5:0]                   o_led
);

    // pclk check handshake
    logic pclk_start;
    logic pclk_done;
    logic pclk_ok;

    pclk_monitor pclk_monitor_i (
        .cam_port    (cam_port    ),
        .rst_n       (rst_n       ),
        .i_cmos_pclk (i_cmos_pclk ),
        .i_start     (pclk_start  ),
        .o_done      (pclk_done   ),
        .o_ok        (pclk_ok     )
    );

    bringup_ctrl bringup_ctrl_i (
        .cam_port        (cam_port        ),
        .rst_n           (rst_n           ),
        .i_mac_init_done (i_mac_init_done ),
        .i_cam_init_done (i_cam_init_done ),
        .i_pclk_done     (pclk_done       ),
        .i_pclk_ok       (pclk_ok         ),
        .i_mac_mdc       (i_mac_mdc       ),
        .i_mac_mdio_o    (i_mac_mdio_o    ),
        .i_mac_mdio_oe   (i_mac_mdio_oe   ),
        .i_cam_scl_o     (i_cam_scl_o     ),
        .i_cam_scl_oe    (i_cam_scl_oe    ),
        .i_cam_sda_o     (i_cam_sda_o     ),
        .i_cam_sda_oe    (i_cam_sda_oe    ),
        .o_pclk_start    (pclk_start      ),
        .o_mac_rst_n     (o_mac_rst_n     ),
        .o_cam_rst_n     (o_cam_rst_n     ),
        .o_stream_en     (o_stream_en     ),
        .o_stage_led     (o_stage_led     ),
        .o_scl_mdc       (o_scl_mdc       ),
        .o_scl_mdc_oe    (o_scl_mdc_oe    ),
        .o_sda_mdio      (o_sda_mdio      ),
        .o_sda_mdio_oe   (o_sda_mdio_oe   )
    );

    rate_meter rate_meter_i (
        .cam_port     (cam_port     ),
        .rst_n        (rst_n        ),
        .i_vsync      (i_vsync      ),
        .i_jpeg_done  (i_jpeg_done  ),
        .o_frame_rate (o_frame_rate ),
        .o_jpeg_rate  (o_jpeg_rate  ),
        .o_frame_led  (o_frame_led  ),
        .o_jpeg_led   (o_jpeg_led   )
    );

    // frame led on top, then jpeg, then the stage leds
    assign o_led = {o_frame_led, o_jpeg_led, o_stage_led};

endmodule

`default_nettype wire

// File: rtl/rate_meter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_bringup_cfg.svh"

module rate_meter (
    input  logic                         cam_port,
    input  logic                         rst_n,
    input  logic                         i_vsync,
    input  logic                         i_jpeg_done,
    output cam_bringup_pkg::rate_count_t o_frame_rate,
    output cam_bringup_pkg::rate_count_t o_jpeg_rate,
    output logic                         o_frame_led,
    output logic                         o_jpeg_led
);

    localparam int unsigned WIN_W = $clog2(`RATE_WINDOW);

    logic                         vsync_prev;
    logic                         jpeg_prev;
    logic                         frame_rise;
    logic                         jpeg_rise;
    logic [WIN_W-1:0]             win_cnt;
    logic                         win_last;
    cam_bringup_pkg::rate_count_t frame_cnt;
    cam_bringup_pkg::rate_count_t jpeg_cnt;

    assign frame_rise = i_vsync & ~vsync_prev;
    assign jpeg_rise  = i_jpeg_done & ~jpeg_prev;
    assign win_last   = win_cnt == WIN_W'(`RATE_WINDOW - 1);

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            vsync_prev   <= 1'b0;
            jpeg_prev    <= 1'b0;
            win_cnt      <= '0;
            frame_cnt    <= '0;
            jpeg_cnt     <= '0;
            o_frame_rate <= '0;
            o_jpeg_rate  <= '0;
            o_frame_led  <= 1'b1;
            o_jpeg_led   <= 1'b1;
        end else begin
            vsync_prev <= i_vsync;
            jpeg_prev  <= i_jpeg_done;
            // free running, wraps on its own
            win_cnt    <= win_last ? '0 : win_cnt + 1'b1;
            if (win_last) begin
                // an edge on the last cycle goes to the next window
                o_frame_rate <= frame_cnt;
                o_jpeg_rate  <= jpeg_cnt;
                frame_cnt    <= cam_bringup_pkg::rate_count_t'(frame_rise);
                jpeg_cnt     <= cam_bringup_pkg::rate_count_t'(jpeg_rise);
            end else begin
                frame_cnt <= frame_cnt + cam_bringup_pkg::rate_count_t'(frame_rise);
                jpeg_cnt  <= jpeg_cnt + cam_bringup_pkg::rate_count_t'(jpeg_rise);
            end
            // one toggle per event
            if (frame_rise) begin
                o_frame_led <= ~o_frame_led;
            end
            if (jpeg_rise) begin
                o_jpeg_led <= ~o_jpeg_led;
            end
        end
    end

    // an edge needs a low cycle before it
    a_count_bound: assert property (
        @(posedge cam_port) disable iff (!rst_n)
        frame_cnt <= `RATE_WINDOW / 2 && jpeg_cnt <= `RATE_WINDOW / 2
    );

endmodule

`default_nettype wire

// File: rtl/bringup_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_bringup_cfg.svh"

module bringup_ctrl (
    input  logic                    cam_port,
    input  logic                    rst_n,
    input  logic                    i_mac_init_done,
    input  logic                    i_cam_init_done,
    input  logic                    i_pclk_done,
    input  logic                    i_pclk_ok,
    input  logic                    i_mac_mdc,
    input  logic                    i_mac_mdio_o,
    input  logic                    i_mac_mdio_oe,
    input  logic                    i_cam_scl_o,
    input  logic                    i_cam_scl_oe,
    input  logic                    i_cam_sda_o,
    input  logic                    i_cam_sda_oe,
    output logic                    o_pclk_start,
    output logic                    o_mac_rst_n,
    output logic                    o_cam_rst_n,
    output logic                    o_stream_en,
    output logic [`STAGE_LED_W-1:0] o_stage_led,
    output logic                    o_scl_mdc,
    output logic                    o_scl_mdc_oe,
    output logic                    o_sda_mdio,
    output logic                    o_sda_mdio_oe
);

    cam_bringup_pkg::bringup_state_e state;
    cam_bringup_pkg::bus_owner_e     owner;
    logic                            state_chg;

    // every transition below sets this
    // leds shift on it
    always_comb begin
        state_chg = 1'b0;
        case (state)
            cam_bringup_pkg::ST_IDLE:      state_chg = 1'b1;
            cam_bringup_pkg::ST_MAC_INIT:  state_chg = i_mac_init_done;
            cam_bringup_pkg::ST_CAM_INIT:  state_chg = i_cam_init_done;
            cam_bringup_pkg::ST_CAM_CHECK: state_chg = i_pclk_done & ~i_pclk_ok;
            default:                       state_chg = 1'b0;
        endcase
    end

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            state        <= cam_bringup_pkg::ST_IDLE;
            o_pclk_start <= 1'b0;
            o_mac_rst_n  <= 1'b0;
            o_cam_rst_n  <= 1'b0;
            o_stream_en  <= 1'b0;
        end else begin
            // start is a single-cycle pulse
            o_pclk_start <= 1'b0;
            case (state)
                cam_bringup_pkg::ST_IDLE: begin
                    state       <= cam_bringup_pkg::ST_MAC_INIT;
                    o_mac_rst_n <= 1'b1;
                end
                cam_bringup_pkg::ST_MAC_INIT: begin
                    // mac stays out of reset from here on
                    o_mac_rst_n <= 1'b1;
                    if (i_mac_init_done) begin
                        state       <= cam_bringup_pkg::ST_CAM_INIT;
                        o_cam_rst_n <= 1'b1;
                    end
                end
                cam_bringup_pkg::ST_CAM_INIT: begin
                    if (i_cam_init_done) begin
                        state        <= cam_bringup_pkg::ST_CAM_CHECK;
                        o_pclk_start <= 1'b1;
                    end
                end
                cam_bringup_pkg::ST_CAM_CHECK: begin
                    if (i_pclk_done) begin
                        if (i_pclk_ok) begin
                            // pclk alive, keep streaming and check again
                            o_stream_en  <= 1'b1;
                            o_pclk_start <= 1'b1;
                        end else begin
                            // camera lost, redo from mac init
                            state       <= cam_bringup_pkg::ST_MAC_INIT;
                            o_cam_rst_n <= 1'b0;
                            o_stream_en <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= cam_bringup_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // stage leds, left shift with zero fill
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            o_stage_led <= '1;
        end else if (state_chg) begin
            o_stage_led <= {o_stage_led[`STAGE_LED_W-2:0], 1'b0};
        end
    end

    // mac holds the pins until camera init starts
    assign owner = (state == cam_bringup_pkg::ST_IDLE ||
                    state == cam_bringup_pkg::ST_MAC_INIT) ?
                   cam_bringup_pkg::OWNER_MAC : cam_bringup_pkg::OWNER_CAM;

    always_comb begin
        if (owner == cam_bringup_pkg::OWNER_MAC) begin
            // mdc is always driven by the mac
            o_scl_mdc     = i_mac_mdc;
            o_scl_mdc_oe  = 1'b1;
            o_sda_mdio    = i_mac_mdio_o;
            o_sda_mdio_oe = i_mac_mdio_oe;
        end else begin
            o_scl_mdc     = i_cam_scl_o;
            o_scl_mdc_oe  = i_cam_scl_oe;
            o_sda_mdio    = i_cam_sda_o;
            o_sda_mdio_oe = i_cam_sda_oe;
        end
    end

    // stream only while the pclk check keeps passing
    a_stream_in_check: assert property (
        @(posedge cam_port) disable iff (!rst_n)
        o_stream_en |-> state == cam_bringup_pkg::ST_CAM_CHECK
    );

    // camera never leaves reset before the mac
    a_rst_order: assert property (
        @(posedge cam_port) disable iff (!rst_n)
        o_cam_rst_n |-> o_mac_rst_n
    );

endmodule

`default_nettype wire

// File: rtl/pclk_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_bringup_cfg.svh"

module pclk_monitor (
    input  logic cam_port,
    input  logic rst_n,
    input  logic i_cmos_pclk,
    input  logic i_start,
    output logic o_done,
    output logic o_ok
);

    localparam int unsigned WIN_W = $clog2(`PCLK_WINDOW);

    logic [1:0]             pclk_sync;
    logic                   pclk_prev;
    logic                   pclk_rise;
    logic                   busy;
    logic [WIN_W-1:0]       win_cnt;
    logic [`PCLK_CNT_W-1:0] edge_cnt;
    logic                   win_last;

    // pclk is asynchronous, two flops before use
    // prev flop gives the rising edge
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            pclk_sync <= 2'b00;
            pclk_prev <= 1'b0;
        end else begin
            pclk_sync <= {pclk_sync[0], i_cmos_pclk};
            pclk_prev <= pclk_sync[1];
        end
    end

    assign pclk_rise = pclk_sync[1] & ~pclk_prev;

    // start cycle is cycle 0, last counts cycle PCLK_WINDOW
    assign win_last = busy && (win_cnt == WIN_W'(`PCLK_WINDOW - 1));

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            win_cnt  <= '0;
            edge_cnt <= '0;
        end else if (i_start) begin
            busy     <= 1'b1;
            win_cnt  <= '0;
            edge_cnt <= '0;
        end else if (busy) begin
            win_cnt <= win_cnt + 1'b1;
            // saturate so a fast pclk cannot wrap to a fail
            if (pclk_rise && edge_cnt != '1) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
            if (win_last) begin
                busy <= 1'b0;
            end
        end
    end

    // done and ok in the same cycle
    assign o_done = win_last;
    assign o_ok   = edge_cnt >= `PCLK_MIN_EDGES;

    // sequencer only restarts a window after done
    a_start_idle: assert property (
        @(posedge cam_port) disable iff (!rst_n)
        i_start |-> !busy
    );

endmodule

`default_nettype wire

// File: rtl/cam_bringup_pkg.sv
`default_nettype none

`include "cam_bringup_cfg.svh"

package cam_bringup_pkg;

    // bring-up sequencer states
    // idle lasts a single cycle after reset
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_MAC_INIT  = 2'd1,
        ST_CAM_INIT  = 2'd2,
        ST_CAM_CHECK = 2'd3
    } bringup_state_e;

    // owner of the shared scl/mdc and sda/mdio pins
    typedef enum logic {
        OWNER_MAC = 1'b0,
        OWNER_CAM = 1'b1
    } bus_owner_e;

    // events seen in one rate window
    typedef logic [`RATE_W-1:0] rate_count_t;

endpackage

`default_nettype wire

// File: rtl/cam_bringup_cfg.svh
`ifndef CAM_BRINGUP_CFG_SVH
`define CAM_BRINGUP_CFG_SVH

// pixel clock check
// window length in cam_port cycles, kept short for simulation
`define PCLK_WINDOW 64

// fewest synchronized pclk rising edges for a passing window
`define PCLK_MIN_EDGES 16

// edge counter width, saturates at all ones
`define PCLK_CNT_W 8

// frame and jpeg rate meter
// one rate window in cam_port cycles
`define RATE_WINDOW 256

// width of one events-per-window count
// must hold RATE_WINDOW/2
`define RATE_W 8

// stage leds
// one shift per sequencer state change
`define STAGE_LED_W 4

`endif
